// File: hdl/soc_params.svh
// Memory map and sizing constants of the AHB-Lite slave subsystem
// Include in any file that decodes addresses or sizes a slave

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// RAM region, 64 kB window
`define SOC_RAM_BASE   32'h0011_0000
`define SOC_RAM_MASK   32'hFFFF_0000

// Timer region, 4 kB window
`define SOC_TIMER_BASE 32'h0020_0000
`define SOC_TIMER_MASK 32'hFFFF_F000

// Physical RAM size in bytes
`define SOC_RAM_BYTES  4096

// Number of compare registers
`define SOC_TIMER_CNT  3

`endif

// File: hdl/ahbPkg.sv
// AHB-Lite protocol types shared by the slave subsystem
// Import into any module that touches the request or response bus

package ahbPkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  typedef logic [31:0] haddrT;
  typedef logic [31:0] hdataT;

  // Transfer type as driven by the master
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  // Only the sizes that fit a 32-bit bus
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsizeT;

  //////////////////////////////////////////////////
  // Address phase and response bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic   hsel;
    haddrT  haddr;
    logic   hwrite;
    hsizeT  hsize;
    htransT htrans;
  } ahbReqT;

  // hresp low means OKAY, high means ERROR
  typedef struct packed {
    hdataT hrdata;
    logic  hreadyout;
    logic  hresp;
  } ahbRspT;

endpackage

// File: hdl/socMapPkg.sv
// Memory map types of the subsystem
// Carries the decoded data-phase record and the timer register width

package socMapPkg;

  import ahbPkg::*;

  // Which slave owns the transfer in its data phase
  typedef enum logic [1:0] {
    SEL_RAM   = 2'b00,
    SEL_TIMER = 2'b01,
    SEL_NONE  = 2'b10
  } slaveSelT;

  // Byte address inside a region
  typedef logic [11:0] offsetT;

  // Timer counter and compare width
  typedef logic [31:0] tickT;

  // Transfer now in its data phase
  typedef struct packed {
    logic     valid;
    slaveSelT sel;
    offsetT   offset;
    logic     hwrite;
    hsizeT    hsize;
  } dataPhaseT;

endpackage

// File: hdl/ahbAddrDecode.sv
// Address-phase decoder
// Samples an accepted transfer and presents it to the slaves as a
// data-phase record for the following cycle(s)

`include "soc_params.svh"

module ahbAddrDecode
  import ahbPkg::*;
  import socMapPkg::*;
(
  input  logic      clk_ahb_i,
  input  logic      arstN_i,
  input  ahbReqT    req_i,
  input  logic      hready_i,
  output dataPhaseT dphase_o
);

  logic     xferReq;
  slaveSelT addrSel;

  // NONSEQ or SEQ with the slave selected
  assign xferReq = req_i.hsel && (req_i.htrans == NONSEQ || req_i.htrans == SEQ);

  // Region match on the masked address
  always_comb begin
    if ((req_i.haddr & `SOC_RAM_MASK) == `SOC_RAM_BASE) begin
      addrSel = SEL_RAM;
    end else if ((req_i.haddr & `SOC_TIMER_MASK) == `SOC_TIMER_BASE) begin
      addrSel = SEL_TIMER;
    end else begin
      addrSel = SEL_NONE;
    end
  end

  // Record only moves on when the bus is ready
  always_ff @(posedge clk_ahb_i or negedge arstN_i) begin
    if (!arstN_i) begin
      dphase_o <= '0;
    end else if (hready_i) begin
      dphase_o.valid <= xferReq;
      if (xferReq) begin
        dphase_o.sel    <= addrSel;
        dphase_o.offset <= req_i.haddr[11:0];
        dphase_o.hwrite <= req_i.hwrite;
        dphase_o.hsize  <= req_i.hsize;
      end
    end
  end

endmodule

// File: hdl/ahbRamSlave.sv
// On-chip RAM slave, zero wait states
// Reads come straight from the array, writes land at the end of the
// data phase through per-byte lane enables

`include "soc_params.svh"

module ahbRamSlave
  import ahbPkg::*;
  import socMapPkg::*;
(
  input  logic      clk_ahb_i,
  input  logic      arstN_i,
  input  dataPhaseT dphase_i,
  input  hdataT     hwdata_i,
  output ahbRspT    rsp_o
);

  localparam int ramWords = `SOC_RAM_BYTES / 4;
  localparam int idxW     = $clog2(ramWords);

  hdataT            mem [ramWords];
  logic [idxW-1:0]  wordIdx;
  logic [3:0]       byteEn;
  logic             wrEn;

  assign wordIdx = dphase_i.offset[idxW+1:2];

  // Writes blocked while reset is held
  assign wrEn = arstN_i && dphase_i.valid && dphase_i.hwrite && (dphase_i.sel == SEL_RAM);

  //////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////

  always_comb begin
    case (dphase_i.hsize)
      BYTE:    byteEn = 4'b0001 << dphase_i.offset[1:0];
      HALF:    byteEn = dphase_i.offset[1] ? 4'b1100 : 4'b0011;
      default: byteEn = 4'b1111;
    endcase
  end

  always_ff @(posedge clk_ahb_i) begin
    if (wrEn) begin
      for (int b = 0; b < 4; b++) begin
        if (byteEn[b]) begin
          mem[wordIdx][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  // Always ready, always OKAY
  always_comb begin
    rsp_o.hrdata    = mem[wordIdx];
    rsp_o.hreadyout = 1'b1;
    rsp_o.hresp     = 1'b0;
  end

endmodule

// File: hdl/ahbTimerSlave.sv
// Machine timer slave
// Free-running counter at offset 0 and compare registers from offset 4
// upwards; tint_o rises once the counter reaches any compare value

`include "soc_params.svh"

module ahbTimerSlave
  import ahbPkg::*;
  import socMapPkg::*;
(
  input  logic      clk_ahb_i,
  input  logic      arstN_i,
  input  dataPhaseT dphase_i,
  input  hdataT     hwdata_i,
  output ahbRspT    rsp_o,
  output logic      tint_o
);

  tickT       cnt;
  tickT       cmp [`SOC_TIMER_CNT];
  tickT       rdVal;
  logic [9:0] wordIdx;
  logic       wrEn;

  assign wordIdx = dphase_i.offset[11:2];
  assign wrEn    = dphase_i.valid && dphase_i.hwrite && (dphase_i.sel == SEL_TIMER);

  //////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////

  // Load takes priority over the increment
  always_ff @(posedge clk_ahb_i or negedge arstN_i) begin
    if (!arstN_i) begin
      cnt <= '0;
    end else if (wrEn && wordIdx == 10'd0) begin
      cnt <= hwdata_i;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Compare registers
  //////////////////////////////////////////////////

  // All ones keeps the interrupt quiet
  always_ff @(posedge clk_ahb_i or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int i = 0; i < `SOC_TIMER_CNT; i++) begin
        cmp[i] <= '1;
      end
    end else if (wrEn) begin
      for (int i = 0; i < `SOC_TIMER_CNT; i++) begin
        if (wordIdx == 10'(i + 1)) begin
          cmp[i] <= hwdata_i;
        end
      end
    end
  end

  always_comb begin
    tint_o = 1'b0;
    for (int i = 0; i < `SOC_TIMER_CNT; i++) begin
      if (cnt >= cmp[i]) begin
        tint_o = 1'b1;
      end
    end
  end

  // Counter here already holds the value loaded at the capture edge
  always_comb begin
    rdVal = '0;
    if (wordIdx == 10'd0) begin
      rdVal = cnt;
    end
    for (int i = 0; i < `SOC_TIMER_CNT; i++) begin
      if (wordIdx == 10'(i + 1)) begin
        rdVal = cmp[i];
      end
    end
  end

  always_comb begin
    rsp_o.hrdata    = rdVal;
    rsp_o.hreadyout = 1'b1;
    rsp_o.hresp     = 1'b0;
  end

endmodule

// File: hdl/ahbRespMux.sv
// Response multiplexer with the built-in default slave
// Returns the selected slave's response and answers unmapped transfers
// with the two-cycle ERROR sequence

module ahbRespMux
  import ahbPkg::*;
  import socMapPkg::*;
(
  input  logic      clk_ahb_i,
  input  logic      arstN_i,
  input  dataPhaseT dphase_i,
  input  ahbRspT    ramRsp_i,
  input  ahbRspT    timerRsp_i,
  output ahbRspT    rsp_o,
  output logic      hready_o
);

  typedef enum logic {
    ERR_IDLE,
    ERR_HOLD
  } errStateT;

  errStateT errState;
  logic     errStart;

  assign errStart = dphase_i.valid && (dphase_i.sel == SEL_NONE);

  //////////////////////////////////////////////////
  // Default slave FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_ahb_i or negedge arstN_i) begin
    if (!arstN_i) begin
      errState <= ERR_IDLE;
    end else begin
      case (errState)
        ERR_IDLE: if (errStart) errState <= ERR_HOLD;
        ERR_HOLD: errState <= ERR_IDLE;
        default:  errState <= ERR_IDLE;
      endcase
    end
  end

  // Idle bus answers OKAY and ready
  always_comb begin
    rsp_o = '{hrdata: '0, hreadyout: 1'b1, hresp: 1'b0};
    if (dphase_i.valid) begin
      case (dphase_i.sel)
        SEL_RAM:   rsp_o = ramRsp_i;
        SEL_TIMER: rsp_o = timerRsp_i;
        default: begin
          // Wait state first, then ready with ERROR still up
          rsp_o.hreadyout = (errState == ERR_HOLD);
          rsp_o.hresp     = 1'b1;
        end
      endcase
    end
  end

  assign hready_o = rsp_o.hreadyout;

endmodule

// File: hdl/ahbSubsysTop.sv
// Top level of the AHB-Lite slave subsystem
// One master port in, RAM and timer slaves behind a single decoder

module ahbSubsysTop
  import ahbPkg::*;
  import socMapPkg::*;
(
  input  logic   clk_ahb_i,
  input  logic   arstN_i,
  input  ahbReqT req_i,
  input  hdataT  hwdata_i,
  output ahbRspT rsp_o,
  output logic   tint_o
);

  dataPhaseT dphase;
  logic      hready;
  ahbRspT    ramRsp;
  ahbRspT    timerRsp;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  ahbAddrDecode addrDecode (
    .clk_ahb_i(clk_ahb_i),
    .arstN_i  (arstN_i),
    .req_i    (req_i),
    .hready_i (hready),
    .dphase_o (dphase)
  );

  //////////////////////////////////////////////////
  // Slaves
  //////////////////////////////////////////////////

  ahbRamSlave ramSlave (
    .clk_ahb_i(clk_ahb_i),
    .arstN_i  (arstN_i),
    .dphase_i (dphase),
    .hwdata_i (hwdata_i),
    .rsp_o    (ramRsp)
  );

  ahbTimerSlave timerSlave (
    .clk_ahb_i(clk_ahb_i),
    .arstN_i  (arstN_i),
    .dphase_i (dphase),
    .hwdata_i (hwdata_i),
    .rsp_o    (timerRsp),
    .tint_o   (tint_o)
  );

  // Response back to the master
  ahbRespMux respMux (
    .clk_ahb_i (clk_ahb_i),
    .arstN_i   (arstN_i),
    .dphase_i  (dphase),
    .ramRsp_i  (ramRsp),
    .timerRsp_i(timerRsp),
    .rsp_o     (rsp_o),
    .hready_o  (hready)
  );

endmodule

// File: dv/tbAhbSubsys.sv
// Self-checking testbench of the AHB-Lite slave subsystem
// Acts as the only bus master, runs random RAM, timer and unmapped
// transfers from a fixed seed and checks them against a reference model

`include "soc_params.svh"

module tbAhbSubsys
  import ahbPkg::*;
  import socMapPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod  = 40;
  localparam int maxXfers   = 400;
  localparam int watchdogNs = maxXfers * 3 * clkPeriod + 4000;

  localparam ahbReqT idleReq = '{hsel: 1'b0, haddr: '0, hwrite: 1'b0, hsize: WORD, htrans: IDLE};

  logic   clkAhb;
  logic   arstN;
  ahbReqT req;
  hdataT  hwdata;
  ahbRspT rsp;
  logic   tint;

  // Reference model state
  hdataT       ramModel [1024];
  int          written [$];
  tickT        cntModel;
  tickT        cmpModel [`SOC_TIMER_CNT];
  logic [31:0] rngState;

  // Write data owed to the transfer in data phase, and the request records
  hdataT  pendWdata;
  ahbReqT lastReq;
  ahbReqT curReq;

  ahbSubsysTop DUT (
    .clk_ahb_i(clkAhb),
    .arstN_i  (arstN),
    .req_i    (req),
    .hwdata_i (hwdata),
    .rsp_o    (rsp),
    .tint_o   (tint)
  );

  initial begin
    clkAhb = 1'b0;
    forever #(clkPeriod / 2) clkAhb = ~clkAhb;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic ahbReqT buildReq(haddrT addr, logic write, hsizeT size);
    ahbReqT r;
    r.hsel   = 1'b1;
    r.haddr  = addr;
    r.hwrite = write;
    r.hsize  = size;
    r.htrans = NONSEQ;
    return r;
  endfunction

  function automatic ahbRspT okRsp(hdataT data);
    return '{hrdata: data, hreadyout: 1'b1, hresp: 1'b0};
  endfunction

  function automatic ahbRspT errRsp(logic ready);
    return '{hrdata: '0, hreadyout: ready, hresp: 1'b1};
  endfunction

  function automatic haddrT ramAddr(int idx);
    return `SOC_RAM_BASE + haddrT'(idx * 4);
  endfunction

  function automatic logic inRam(haddrT addr);
    return (addr & `SOC_RAM_MASK) == `SOC_RAM_BASE;
  endfunction

  function automatic logic inTimer(haddrT addr);
    return (addr & `SOC_TIMER_MASK) == `SOC_TIMER_BASE;
  endfunction

  // Byte lane b is covered by a transfer of this size and address
  function automatic logic laneWritten(ahbReqT r, int b);
    return (r.hsize == WORD) ||
           (r.hsize == HALF && b[1] == r.haddr[1]) ||
           (r.hsize == BYTE && b == int'(r.haddr[1:0]));
  endfunction

  function automatic logic expTint();
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `SOC_TIMER_CNT; i++) begin
      if (cntModel >= cmpModel[i]) hit = 1'b1;
    end
    return hit;
  endfunction

  //////////////////////////////////////////////////
  // Reference model, one step per clock edge
  //////////////////////////////////////////////////

  task automatic stepModel(ahbReqT r, hdataT data);
    haddrT off;
    cntModel = cntModel + 1;
    if (r.hsel && r.htrans == NONSEQ && r.hwrite) begin
      if (inRam(r.haddr)) begin
        for (int b = 0; b < 4; b++) begin
          if (laneWritten(r, b)) ramModel[r.haddr[11:2]][8*b +: 8] = data[8*b +: 8];
        end
      end else if (inTimer(r.haddr)) begin
        off = r.haddr - `SOC_TIMER_BASE;
        if (off == 0) begin
          cntModel = data;
        end else if (off == 4 || off == 8 || off == 12) begin
          cmpModel[off / 4 - 1] = data;
        end
      end
    end
  endtask

  always @(posedge clkAhb or negedge arstN) begin
    if (!arstN) begin
      cntModel = '0;
      for (int i = 0; i < `SOC_TIMER_CNT; i++) cmpModel[i] = '1;
    end else begin
      stepModel(curReq, hwdata);
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic abortRun(string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic checkRsp(string what, ahbRspT exp, ahbRspT act, logic withData);
    if (act.hreadyout !== exp.hreadyout) begin
      abortRun($sformatf("[ERROR] rsp_o.hreadyout expected %h got %h (%s)",
                         exp.hreadyout, act.hreadyout, what));
    end
    if (act.hresp !== exp.hresp) begin
      abortRun($sformatf("[ERROR] rsp_o.hresp expected %h got %h (%s)",
                         exp.hresp, act.hresp, what));
    end
    if (withData && act.hrdata !== exp.hrdata) begin
      abortRun($sformatf("[ERROR] rsp_o.hrdata expected %h got %h (%s)",
                         exp.hrdata, act.hrdata, what));
    end
  endtask

  task automatic checkTint(logic exp, logic act);
    if (act !== exp) begin
      abortRun($sformatf("[ERROR] tint_o expected %h got %h at %0t", exp, act, $time));
    end
  endtask

  // Interrupt follows the model in every cycle
  always @(negedge clkAhb) begin
    if (arstN) checkTint(expTint(), tint);
  end

  //////////////////////////////////////////////////
  // Bus driver, called on the falling edge
  //////////////////////////////////////////////////

  // Next address phase together with the data of the transfer in data phase
  task automatic issue(ahbReqT r, hdataT wd);
    req       = r;
    hwdata    = pendWdata;
    pendWdata = wd;
    curReq    = lastReq;
    lastReq   = r;
    @(negedge clkAhb);
  endtask

  task automatic writeXfer(haddrT addr, hsizeT size, hdataT data);
    issue(buildReq(addr, 1'b1, size), data);
    checkRsp("write", okRsp('0), rsp, 1'b0);
  endtask

  task automatic ramReadCheck(int idx);
    issue(buildReq(ramAddr(idx), 1'b0, WORD), '0);
    checkRsp("RAM read", okRsp(ramModel[idx]), rsp, 1'b1);
  endtask

  task automatic timerReadCheck(haddrT addr, tickT exp);
    issue(buildReq(addr, 1'b0, WORD), '0);
    checkRsp("timer read", okRsp(exp), rsp, 1'b1);
  endtask

  initial begin
    #(watchdogNs);
    abortRun("Timeout: the test sequence did not complete in time");
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int          idx;
    int          gap;
    int          k;
    logic [31:0] r;
    hsizeT       size;
    haddrT       lane;
    haddrT       addr;
    haddrT       cmpAddr;
    tickT        v;

    rngState  = 32'd907;
    arstN     = 1'b0;
    req       = idleReq;
    hwdata    = '0;
    pendWdata = '0;
    lastReq   = idleReq;
    curReq    = idleReq;
    repeat (4) @(posedge clkAhb);
    @(negedge clkAhb);
    arstN = 1'b1;
    checkRsp("after reset", okRsp('0), rsp, 1'b1);

    // RAM word writes, then reads in random order
    for (int n = 0; n < 60; n++) begin
      idx = int'(nextRand() % 1024);
      writeXfer(ramAddr(idx), WORD, nextRand());
      written.push_back(idx);
    end
    for (int n = 0; n < 60; n++) begin
      ramReadCheck(written[nextRand() % written.size()]);
    end

    // Byte and halfword writes into words already written
    for (int n = 0; n < 60; n++) begin
      idx  = written[nextRand() % written.size()];
      r    = nextRand();
      size = r[0] ? BYTE : HALF;
      lane = (size == BYTE) ? haddrT'(r[2:1]) : haddrT'({r[1], 1'b0});
      writeXfer(ramAddr(idx) + lane, size, nextRand());
    end
    for (int n = 0; n < written.size(); n++) ramReadCheck(written[n]);

    // Read address phase overlaps the write data phase
    for (int n = 0; n < 20; n++) begin
      idx = written[nextRand() % written.size()];
      writeXfer(ramAddr(idx), WORD, nextRand());
      ramReadCheck(idx);
    end

    // Counter load, idle gap, then read back
    for (int n = 0; n < 5; n++) begin
      v   = nextRand() & 32'h7FFF_FFFF;
      gap = int'(nextRand() % 16);
      writeXfer(`SOC_TIMER_BASE, WORD, v);
      issue(idleReq, '0);
      repeat (gap) issue(idleReq, '0);
      timerReadCheck(`SOC_TIMER_BASE, tickT'(v + gap + 1));
    end

    // Each compare register raises the interrupt K cycles after the load
    for (int i = 0; i < `SOC_TIMER_CNT; i++) begin
      v       = nextRand() & 32'h7FFF_FFFF;
      k       = 2 + int'(nextRand() % 8);
      cmpAddr = `SOC_TIMER_BASE + haddrT'(4 * (i + 1));
      writeXfer(`SOC_TIMER_BASE, WORD, v);
      writeXfer(cmpAddr, WORD, v + k);
      for (int c = 0; c < k; c++) begin
        checkTint(1'b0, tint);
        issue(idleReq, '0);
      end
      checkTint(1'b1, tint);
      timerReadCheck(cmpAddr, cmpModel[i]);
      writeXfer(cmpAddr, WORD, '1);
      issue(idleReq, '0);
      checkTint(1'b0, tint);
    end

    // Unused timer offset reads as zero
    timerReadCheck(`SOC_TIMER_BASE + 32'h10, '0);

    // Unmapped transfers get the two-cycle ERROR response
    for (int n = 0; n < 8; n++) begin
      do begin
        addr = nextRand();
      end while (inRam(addr) || inTimer(addr));
      r = nextRand();
      issue(buildReq(addr, r[0], WORD), nextRand());
      checkRsp("error wait state", errRsp(1'b0), rsp, 1'b1);
      issue(idleReq, '0);
      checkRsp("error last cycle", errRsp(1'b1), rsp, 1'b1);
      ramReadCheck(written[nextRand() % written.size()]);
    end

    issue(idleReq, '0);
    issue(idleReq, '0);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: ahbSubsysTop.f
+incdir+hdl
hdl/ahbPkg.sv
hdl/socMapPkg.sv
hdl/ahbAddrDecode.sv
hdl/ahbRamSlave.sv
hdl/ahbTimerSlave.sv
hdl/ahbRespMux.sv
hdl/ahbSubsysTop.sv
dv/tbAhbSubsys.sv

// File: Bender.yml
package:
  name: ahb_subsys

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/ahbPkg.sv
      - hdl/socMapPkg.sv
      - hdl/ahbAddrDecode.sv
      - hdl/ahbRamSlave.sv
      - hdl/ahbTimerSlave.sv
      - hdl/ahbRespMux.sv
      - hdl/ahbSubsysTop.sv
  - target: simulation
    files:
      - dv/tbAhbSubsys.sv
